// ==== axi_engine/axi_read_engine.sv ====
`timescale 1ns/1ps

module axi_read_engine
  import bridge_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  cmd_if.sink                   cmd_i,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  output logic [ADDR_WIDTH-1:0] araddr_o,
  output logic [ID_WIDTH-1:0]   arid_o,
  output logic [7:0]            arlen_o,
  output logic [1:0]            arburst_o,
  input  logic                  rvalid_i,
  output logic                  rready_o,
  input  logic                  rlast_i,
  input  logic [1:0]            rresp_i,
  input  logic [DATA_WIDTH-1:0] rdata_i,
  output logic                  beat_valid_o,
  input  logic                  beat_ready_i,
  output rbeat_t                beat_o
);

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

  rd_state_e state_q;
  logic      done_q;
  logic      err_q;
  logic      r_hs;
  cmd_t      cmd_q;

  assign cmd_i.ready    = state_q == RD_IDLE && cmd_i.cmd.dir;
  assign cmd_i.done     = done_q;
  assign cmd_i.resp_err = err_q;

  assign arvalid_o = state_q == RD_ADDR;
  assign araddr_o  = cmd_q.addr;
  assign arid_o    = cmd_q.tag;
  assign arlen_o   = cmd_q.beats_m1;
  assign arburst_o = BURST_INCR;

  // R beats go straight into the read FIFO
  assign rready_o     = state_q == RD_DATA && beat_ready_i;
  assign beat_valid_o = state_q == RD_DATA && rvalid_i;
  assign beat_o.data  = rdata_i;
  assign beat_o.last  = rlast_i;
  assign r_hs         = rvalid_i && rready_o;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= RD_IDLE;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        RD_IDLE: if (cmd_i.valid && cmd_i.ready) begin
          state_q <= RD_ADDR;
          err_q   <= 1'b0;
        end
        RD_ADDR: if (arready_i) state_q <= RD_DATA;
        default: if (r_hs) begin
          if (rresp_i != RESP_OKAY) err_q <= 1'b1;  // Sticky over the burst
          if (rlast_i) begin
            state_q <= RD_IDLE;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_i.valid && cmd_i.ready) cmd_q <= cmd_i.cmd;
  end

endmodule

// ==== axi_engine/axi_write_engine.sv ====
`timescale 1ns/1ps

module axi_write_engine
  import bridge_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  cmd_if.sink                   cmd_i,
  input  logic                  beat_valid_i,
  output logic                  beat_ready_o,
  input  wbeat_t                beat_i,
  output logic                  awvalid_o,
  input  logic                  awready_i,
  output logic [ADDR_WIDTH-1:0] awaddr_o,
  output logic [ID_WIDTH-1:0]   awid_o,
  output logic [7:0]            awlen_o,
  output logic [1:0]            awburst_o,
  output logic                  wvalid_o,
  input  logic                  wready_i,
  output logic                  wlast_o,
  output logic [STROBES-1:0]    wstrb_o,
  output logic [DATA_WIDTH-1:0] wdata_o,
  input  logic                  bvalid_i,
  output logic                  bready_o,
  input  logic [1:0]            bresp_i
);

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

  wr_state_e state_q;
  logic [7:0] cnt_q;  // Beats sent so far
  logic       done_q;
  logic       err_q;
  cmd_t       cmd_q;

  assign cmd_i.ready    = state_q == WR_IDLE && !cmd_i.cmd.dir;
  assign cmd_i.done     = done_q;
  assign cmd_i.resp_err = err_q;

  assign awvalid_o = state_q == WR_ADDR;
  assign awaddr_o  = cmd_q.addr;
  assign awid_o    = cmd_q.tag;
  assign awlen_o   = cmd_q.beats_m1;
  assign awburst_o = BURST_INCR;

  assign wvalid_o     = state_q == WR_DATA && beat_valid_i;
  assign beat_ready_o = state_q == WR_DATA && wready_i;
  assign wlast_o      = cnt_q == cmd_q.beats_m1;
  assign wstrb_o      = '1;
  assign wdata_o      = beat_i.data;
  assign bready_o     = state_q == WR_RESP;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= WR_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        WR_IDLE: if (cmd_i.valid && cmd_i.ready) state_q <= WR_ADDR;
        WR_ADDR: begin
          cnt_q <= '0;
          if (awready_i) state_q <= WR_DATA;
        end
        WR_DATA: if (wvalid_o && wready_i) begin
          cnt_q <= cnt_q + 8'd1;
          if (wlast_o) state_q <= WR_RESP;
        end
        default: if (bvalid_i) begin
          state_q <= WR_IDLE;
          done_q  <= 1'b1;
          err_q   <= bresp_i != RESP_OKAY;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_i.valid && cmd_i.ready) cmd_q <= cmd_i.cmd;
  end

endmodule

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
  import bridge_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic [3:0]            stall_i,  // 1 allows awready, wready, arready, rvalid
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic [ID_WIDTH-1:0]   awid_i,
  input  logic [7:0]            awlen_i,
  input  logic [1:0]            awburst_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  input  logic                  wlast_i,
  input  logic [STROBES-1:0]    wstrb_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  output logic [1:0]            bresp_o,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic [ID_WIDTH-1:0]   arid_i,
  input  logic [7:0]            arlen_i,
  input  logic [1:0]            arburst_i,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output logic                  rlast_o,
  output logic [1:0]            rresp_o,
  output logic [DATA_WIDTH-1:0] rdata_o,
  // Fields of the last address handshake, for the testbench to compare
  output logic [ADDR_WIDTH-1:0] last_addr_o,
  output logic [ID_WIDTH-1:0]   last_id_o,
  output logic [7:0]            last_len_o,
  output logic [1:0]            last_burst_o,
  output logic                  strb_bad_o
);

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [DATA_WIDTH-1:0] mem [1024];  // 4 KiB, upper address bits ignored
  logic [9:0]            w_ptr;
  logic [9:0]            r_ptr;
  logic [7:0]            r_left;
  logic                  w_act;
  logic                  w_err;
  logic                  r_act;
  logic                  r_err;

  // Byte addresses 0xE00 to 0xEFF answer with SLVERR
  function automatic logic in_err(input logic [ADDR_WIDTH-1:0] a);
    return a[11:8] == 4'hE;
  endfunction

  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'hA5;
  endfunction

  initial begin
    for (int i = 0; i < 4096; i++) mem[i / 4][(i % 4) * 8 +: 8] = fill_byte(12'(i));
  end

  assign awready_o = aresetn && !w_act && !bvalid_o && stall_i[0];
  assign wready_o  = w_act && stall_i[1];
  assign arready_o = aresetn && !r_act && stall_i[2];
  assign rdata_o   = mem[r_ptr];
  assign rlast_o   = r_left == 8'd0;
  assign rresp_o   = r_err ? RESP_SLVERR : RESP_OKAY;

  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      w_act      <= 1'b0;
      r_act      <= 1'b0;
      bvalid_o   <= 1'b0;
      bresp_o    <= RESP_OKAY;
      rvalid_o   <= 1'b0;
      strb_bad_o <= 1'b0;
    end else begin
      if (awvalid_i && awready_o) begin
        w_act        <= 1'b1;
        w_ptr        <= awaddr_i[11:2];
        w_err        <= in_err(awaddr_i);
        last_addr_o  <= awaddr_i;
        last_id_o    <= awid_i;
        last_len_o   <= awlen_i;
        last_burst_o <= awburst_i;
      end
      if (wvalid_i && wready_o) begin
        if (!w_err) mem[w_ptr] <= wdata_i;  // Error range stays untouched
        if (wstrb_i != '1) strb_bad_o <= 1'b1;
        w_ptr <= w_ptr + 10'd1;
        if (wlast_i) begin
          w_act    <= 1'b0;
          bvalid_o <= 1'b1;
          bresp_o  <= w_err ? RESP_SLVERR : RESP_OKAY;
        end
      end
      if (bvalid_o && bready_i) bvalid_o <= 1'b0;
      if (arvalid_i && arready_o) begin
        r_act        <= 1'b1;
        r_ptr        <= araddr_i[11:2];
        r_left       <= arlen_i;
        r_err        <= in_err(araddr_i);
        last_addr_o  <= araddr_i;
        last_id_o    <= arid_i;
        last_len_o   <= arlen_i;
        last_burst_o <= arburst_i;
      end
      if (rvalid_o && rready_i) begin
        r_ptr    <= r_ptr + 10'd1;
        r_left   <= r_left - 8'd1;
        if (r_left == 8'd0) r_act <= 1'b0;
        rvalid_o <= r_left != 8'd0 && stall_i[3];
      end else if (r_act && stall_i[3]) begin
        rvalid_o <= 1'b1;  // Held until rready
      end
    end
  end

endmodule

// ==== bench/tb_cmd_to_axi.sv ====
`timescale 1ns/1ps

module tb_cmd_to_axi
  import bridge_pkg::*;
();

  localparam int TOTAL_BYTES = 2232;  // Sum of all bytes moved by the tests below
  localparam int LIMIT       = 40 * TOTAL_BYTES + 1000;

  logic aclk;
  logic aresetn;
  logic cmd_vld_i, cmd_ack_i, cmd_dir_i, cmd_err_o;
  logic [ID_WIDTH-1:0] cmd_tag_i;
  logic [15:0] cmd_len_i, cmd_res_o;
  logic [3:0] cmd_lun_i;
  logic [27:0] cmd_adr_i;
  logic dat_tvalid_i, dat_tready_o, dat_tlast_i;
  logic [7:0] dat_tdata_i, dat_tdata_o;
  logic dat_tvalid_o, dat_tready_i, dat_tkeep_o, dat_tlast_o;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  logic [ADDR_WIDTH-1:0] awaddr, araddr, last_addr;
  logic [ID_WIDTH-1:0] awid, arid, last_id;
  logic [7:0] awlen, arlen, last_len;
  logic [1:0] awburst, arburst, last_burst, bresp, rresp;
  logic [STROBES-1:0] wstrb;
  logic [DATA_WIDTH-1:0] wdata, rdata;
  logic strb_bad;
  logic [3:0] stall;
  logic stall_on;

  logic [15:0] dst;  // LFSR state for data bytes
  logic [15:0] sst;  // LFSR state for stall decisions
  logic [7:0]  wbuf [1024];
  logic [7:0]  shadow [4096];
  logic [11:0] rd_base;
  int          rd_len;
  int          rd_cnt;
  int          checks;
  int          errors;
  int          tests;
  int          cycles;

  cmd_to_axi #(.FIFO_DEPTH(16)) cmd_to_axi_i (
    .aclk, .aresetn,
    .cmd_vld_i, .cmd_ack_i, .cmd_dir_i, .cmd_tag_i, .cmd_len_i, .cmd_lun_i, .cmd_adr_i,
    .cmd_err_o, .cmd_res_o,
    .dat_tvalid_i, .dat_tready_o, .dat_tlast_i, .dat_tdata_i,
    .dat_tvalid_o, .dat_tready_i, .dat_tkeep_o, .dat_tlast_o, .dat_tdata_o,
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awid_o(awid),
    .awlen_o(awlen), .awburst_o(awburst),
    .wvalid_o(wvalid), .wready_i(wready), .wlast_o(wlast), .wstrb_o(wstrb), .wdata_o(wdata),
    .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arid_o(arid),
    .arlen_o(arlen), .arburst_o(arburst),
    .rvalid_i(rvalid), .rready_o(rready), .rlast_i(rlast), .rresp_i(rresp), .rdata_i(rdata)
  );

  axi_mem_model u_mem (
    .aclk, .aresetn, .stall_i(stall),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awid_i(awid),
    .awlen_i(awlen), .awburst_i(awburst),
    .wvalid_i(wvalid), .wready_o(wready), .wlast_i(wlast), .wstrb_i(wstrb), .wdata_i(wdata),
    .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arid_i(arid),
    .arlen_i(arlen), .arburst_i(arburst),
    .rvalid_o(rvalid), .rready_i(rready), .rlast_o(rlast), .rresp_o(rresp), .rdata_o(rdata),
    .last_addr_o(last_addr), .last_id_o(last_id), .last_len_o(last_len),
    .last_burst_o(last_burst), .strb_bad_o(strb_bad)
  );

  always #2 aclk = ~aclk;

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic take_bit(inout logic [15:0] st);
    logic b;
    b  = st[0];
    st = st >> 1;
    if (b) st = st ^ 16'hB400;
    return b;
  endfunction

  function automatic logic [7:0] take_byte(inout logic [15:0] st);
    logic [7:0] v;
    for (int i = 0; i < 8; i++) v[i] = take_bit(st);
    return v;
  endfunction

  function automatic logic ready_bit(inout logic [15:0] st);
    logic a;
    logic b;
    a = take_bit(st);
    b = take_bit(st);
    return a | b;  // High three times in four
  endfunction

  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'hA5;
  endfunction

  // Expected memory byte from the shadow kept by the write tests
  function automatic logic [7:0] ref_byte(input logic [11:0] a);
    return shadow[a];
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  always @(posedge aclk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout: the run took more than %0d cycles", LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  always @(posedge aclk) begin
    #1;
    if (stall_on) begin
      dat_tready_i = ready_bit(sst);
      for (int k = 0; k < 4; k++) stall[k] = ready_bit(sst);
    end else begin
      dat_tready_i = 1'b1;
      stall        = 4'hF;
    end
  end

  // Compares every outbound byte
  always @(posedge aclk) begin
    if (aresetn && dat_tvalid_o && dat_tready_i) begin
      check("read byte", 32'(dat_tdata_o), 32'(ref_byte(12'(32'(rd_base) + rd_cnt))));
      check("tlast", 32'(dat_tlast_o), 32'(rd_cnt == rd_len - 1));
      check("tkeep", 32'(dat_tkeep_o), 32'd1);
      check("read residue", 32'(cmd_res_o), 32'(rd_len - rd_cnt));
      rd_cnt++;
    end
  end

  task automatic send_bytes(input int n);
    int   idx;
    logic hs;
    idx = 0;
    while (idx < n) begin
      if (!dat_tvalid_i && (!stall_on || ready_bit(dst))) begin
        dat_tvalid_i = 1'b1;
        dat_tdata_i  = wbuf[idx];
        dat_tlast_i  = idx == n - 1;
      end
      @(posedge aclk);
      hs = dat_tvalid_i && dat_tready_o;
      #1;
      if (hs) begin
        idx++;
        dat_tvalid_i = 1'b0;
        check("write residue", 32'(cmd_res_o), 32'(n - idx));
      end
    end
  endtask

  task automatic run_cmd(input logic dir, input logic [3:0] tag, input logic [3:0] lun,
                         input logic [27:0] adr, input int n, input logic exp_err);
    if (!dir) begin
      for (int i = 0; i < n; i++) wbuf[i] = take_byte(dst);
    end
    rd_base   = adr[11:0];
    rd_len    = n;
    rd_cnt    = 0;
    cmd_dir_i = dir;
    cmd_tag_i = tag;
    cmd_lun_i = lun;
    cmd_adr_i = adr;
    cmd_len_i = 16'(n);
    cmd_vld_i = 1'b1;
    if (!dir) begin
      send_bytes(n);
      do @(posedge aclk); while (!(bvalid && bready));
      if (adr[11:8] != 4'hE) begin
        for (int i = 0; i < n; i++) shadow[12'(32'(adr[11:0]) + i)] = wbuf[i];
      end
    end else begin
      do begin
        @(posedge aclk);
        #1;
      end while (rd_cnt < n);
    end
    repeat (2) @(posedge aclk);  // Let done and then the error flag settle
    #1;
    check("axaddr", last_addr, {lun, adr});
    check("axlen", 32'(last_len), 32'(n / 4 - 1));
    check("axid", 32'(last_id), 32'(tag));
    check("axburst", 32'(last_burst), 32'd1);
    check("wstrb all ones", 32'(strb_bad), 32'd0);
    check("final residue", 32'(cmd_res_o), 32'd0);
    check("cmd_err", 32'(cmd_err_o), 32'(exp_err));
    cmd_ack_i = 1'b1;
    cmd_vld_i = 1'b0;
    @(posedge aclk);
    #1;
    cmd_ack_i = 1'b0;
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - err_before);
  endtask

  initial begin
    int e;
    aclk = 0;
    aresetn = 0;
    cmd_vld_i = 0;
    cmd_ack_i = 0;
    cmd_dir_i = 0;
    cmd_tag_i = '0;
    cmd_len_i = '0;
    cmd_lun_i = '0;
    cmd_adr_i = '0;
    dat_tvalid_i = 0;
    dat_tlast_i = 0;
    dat_tdata_i = '0;
    dat_tready_i = 1;
    stall = 4'hF;
    stall_on = 0;
    dst = 16'd3552;
    sst = 16'd3552;
    checks = 0;
    errors = 0;
    tests = 0;
    cycles = 0;
    rd_base = '0;
    rd_len = 0;
    rd_cnt = 0;
    for (int i = 0; i < 4096; i++) shadow[i] = fill_byte(12'(i));
    repeat (8) @(posedge aclk);
    #1;
    check("outputs in reset", 32'({awvalid, wvalid, bready, arvalid, rready,
                                   dat_tvalid_o, dat_tready_o, cmd_err_o}), 32'd0);
    aresetn = 1;
    repeat (2) @(posedge aclk);
    #1;

    e = errors;
    run_cmd(1'b0, 4'd1, 4'd2, 28'h100, 64, 1'b0);
    run_cmd(1'b1, 4'd2, 4'd2, 28'h100, 64, 1'b0);
    end_test("write and read 64 bytes", e);

    e = errors;
    stall_on = 1;
    run_cmd(1'b0, 4'd3, 4'd3, 28'h040, 4, 1'b0);
    run_cmd(1'b1, 4'd4, 4'd3, 28'h040, 4, 1'b0);
    end_test("single beat with stalls", e);

    e = errors;
    run_cmd(1'b0, 4'd5, 4'd1, 28'h000, 1024, 1'b0);
    run_cmd(1'b1, 4'd6, 4'd1, 28'h000, 1024, 1'b0);
    end_test("256 beats with stalls", e);

    e = errors;
    run_cmd(1'b0, 4'd7, 4'd0, 28'hE00, 16, 1'b1);
    run_cmd(1'b1, 4'd8, 4'd0, 28'hE00, 16, 1'b1);
    run_cmd(1'b1, 4'd9, 4'd0, 28'h100, 16, 1'b0);
    end_test("error response and clear", e);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== common/bridge_pkg.sv ====
package bridge_pkg;

  // Memory bus geometry
  localparam int DATA_WIDTH = 32;
  localparam int STROBES    = DATA_WIDTH / 8;  // Bytes per beat
  localparam int ADDR_WIDTH = 32;
  localparam int ID_WIDTH   = 4;  // Also the command tag width

  // AXI4 encodings
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] RESP_OKAY  = 2'b00;

  // One decoded command, as handed to the engines
  typedef struct packed {
    logic                  dir;  // 1 = read, 0 = write
    logic [ID_WIDTH-1:0]   tag;
    logic [7:0]            beats_m1;  // AXI burst length minus one
    logic [ADDR_WIDTH-1:0] addr;  // LUN in the top nibble
  } cmd_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } wbeat_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } rbeat_t;

endpackage

// ==== common/cmd_if.sv ====
`timescale 1ns/1ps

interface cmd_if
  import bridge_pkg::*;
();

  logic valid;  // Held until accepted
  logic ready;
  cmd_t cmd;
  logic done;  // One cycle at the end of a burst
  logic resp_err;  // Qualified by done

  // Framer side
  modport source (
    output valid,
    output cmd,
    input  ready,
    input  done,
    input  resp_err
  );

  // Engine side
  modport sink (
    input  valid,
    input  cmd,
    output ready,
    output done,
    output resp_err
  );

  // Observation only
  modport monitor (
    input valid,
    input ready,
    input cmd,
    input done,
    input resp_err
  );

endinterface

// ==== flist.f ====
common/bridge_pkg.sv
common/cmd_if.sv
hdl/cmd_framer.sv
hdl/stream_fifo.sv
hdl/byte_packer.sv
hdl/byte_unpacker.sv
axi_engine/axi_write_engine.sv
axi_engine/axi_read_engine.sv
hdl/cmd_to_axi.sv
bench/axi_mem_model.sv
bench/tb_cmd_to_axi.sv

// ==== hdl/byte_packer.sv ====
`timescale 1ns/1ps

module byte_packer
  import bridge_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       enable_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  logic [7:0] in_data_i,
  input  logic       in_last_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output wbeat_t     out_beat_o
);

  localparam int CW = $clog2(STROBES);

  logic [DATA_WIDTH-1:0] data_q;
  logic                  last_q;
  logic                  full_q;
  logic [CW-1:0]         cnt_q;
  logic                  accept;

  assign in_ready_o  = enable_i && !full_q;  // Stall while a beat waits
  assign accept      = in_valid_i && in_ready_o;
  assign out_valid_o = full_q;

  assign out_beat_o.data = data_q;
  assign out_beat_o.last = last_q;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else if (accept) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CW'(STROBES - 1)) full_q <= 1'b1;
    end else if (out_valid_o && out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Shift in from the top, so the first byte ends up in bits 7:0
  always_ff @(posedge aclk) begin
    if (accept) begin
      data_q <= {in_data_i, data_q[DATA_WIDTH-1:8]};
      if (cnt_q == CW'(STROBES - 1)) last_q <= in_last_i;
    end
  end

endmodule

// ==== hdl/byte_unpacker.sv ====
`timescale 1ns/1ps

module byte_unpacker
  import bridge_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  rbeat_t     in_beat_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output logic [7:0] out_data_o,
  output logic       out_keep_o,
  output logic       out_last_o
);

  localparam int CW = $clog2(STROBES);

  logic [DATA_WIDTH-1:0] data_q;
  logic                  last_q;
  logic                  full_q;
  logic [CW-1:0]         cnt_q;
  logic                  accept;
  logic                  emit;

  assign in_ready_o  = !full_q;
  assign accept      = in_valid_i && in_ready_o;
  assign emit        = out_valid_o && out_ready_i;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q[7:0];
  assign out_keep_o  = 1'b1;  // Whole beats only
  assign out_last_o  = full_q && last_q && cnt_q == CW'(STROBES - 1);

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      full_q <= 1'b1;
      cnt_q  <= '0;
    end else if (emit) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CW'(STROBES - 1)) full_q <= 1'b0;  // Beat used up
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      data_q <= in_beat_i.data;
      last_q <= in_beat_i.last;
    end else if (emit) begin
      data_q <= data_q >> 8;  // Next byte into the low lane
    end
  end

endmodule

// ==== hdl/cmd_framer.sv ====
`timescale 1ns/1ps

module cmd_framer
  import bridge_pkg::*;
(
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                cmd_vld_i,
  input  logic                cmd_ack_i,
  input  logic                cmd_dir_i,
  input  logic [ID_WIDTH-1:0] cmd_tag_i,
  input  logic [15:0]         cmd_len_i,
  input  logic [3:0]          cmd_lun_i,
  input  logic [27:0]         cmd_adr_i,
  input  logic                byte_in_i,
  input  logic                byte_out_i,
  cmd_if.source               cmd_o,
  output logic                busy_o,
  output logic                cmd_err_o,
  output logic [15:0]         cmd_res_o
);

  logic        vld_q;
  logic        valid_q;
  logic        cyc_q;
  logic        err_q;
  logic [15:0] res_q;
  logic [13:0] beats_w;
  logic        stb_w;
  cmd_t        cmd_q;

  assign stb_w   = cmd_vld_i && !vld_q;  // Rising edge of the command valid
  assign beats_w = cmd_len_i[15:2] - 14'd1;

  assign cmd_o.valid = valid_q;
  assign cmd_o.cmd   = cmd_q;
  assign busy_o      = cyc_q;
  assign cmd_err_o   = err_q;
  assign cmd_res_o   = res_q;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      vld_q   <= 1'b0;
      valid_q <= 1'b0;
      cyc_q   <= 1'b0;
      err_q   <= 1'b0;
      res_q   <= '0;
    end else begin
      vld_q <= cmd_vld_i;
      if (stb_w) begin
        valid_q <= 1'b1;
        cyc_q   <= 1'b1;
        err_q   <= 1'b0;  // Each command starts clean
        res_q   <= cmd_len_i;
      end else begin
        if (valid_q && cmd_o.ready) valid_q <= 1'b0;
        if (cmd_ack_i) cyc_q <= 1'b0;
        if (cmd_o.done && cmd_o.resp_err) err_q <= 1'b1;
        if (byte_in_i || byte_out_i) res_q <= res_q - 16'd1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (stb_w) begin
      cmd_q.dir      <= cmd_dir_i;
      cmd_q.tag      <= cmd_tag_i;
      cmd_q.beats_m1 <= beats_w[7:0];
      cmd_q.addr     <= {cmd_lun_i, cmd_adr_i};
    end
  end

endmodule

// ==== hdl/cmd_to_axi.sv ====
`timescale 1ns/1ps

module cmd_to_axi
  import bridge_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  // Decoded command
  input  logic                  cmd_vld_i,
  input  logic                  cmd_ack_i,
  input  logic                  cmd_dir_i,
  input  logic [ID_WIDTH-1:0]   cmd_tag_i,
  input  logic [15:0]           cmd_len_i,
  input  logic [3:0]            cmd_lun_i,
  input  logic [27:0]           cmd_adr_i,
  output logic                  cmd_err_o,
  output logic [15:0]           cmd_res_o,
  // Inbound byte stream, host to memory
  input  logic                  dat_tvalid_i,
  output logic                  dat_tready_o,
  input  logic                  dat_tlast_i,
  input  logic [7:0]            dat_tdata_i,
  // Outbound byte stream, memory to host
  output logic                  dat_tvalid_o,
  input  logic                  dat_tready_i,
  output logic                  dat_tkeep_o,
  output logic                  dat_tlast_o,
  output logic [7:0]            dat_tdata_o,
  // AXI4 master
  output logic                  awvalid_o,
  input  logic                  awready_i,
  output logic [ADDR_WIDTH-1:0] awaddr_o,
  output logic [ID_WIDTH-1:0]   awid_o,
  output logic [7:0]            awlen_o,
  output logic [1:0]            awburst_o,
  output logic                  wvalid_o,
  input  logic                  wready_i,
  output logic                  wlast_o,
  output logic [STROBES-1:0]    wstrb_o,
  output logic [DATA_WIDTH-1:0] wdata_o,
  input  logic                  bvalid_i,
  output logic                  bready_o,
  input  logic [1:0]            bresp_i,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  output logic [ADDR_WIDTH-1:0] araddr_o,
  output logic [ID_WIDTH-1:0]   arid_o,
  output logic [7:0]            arlen_o,
  output logic [1:0]            arburst_o,
  input  logic                  rvalid_i,
  output logic                  rready_o,
  input  logic                  rlast_i,
  input  logic [1:0]            rresp_i,
  input  logic [DATA_WIDTH-1:0] rdata_i
);

  logic   busy;
  logic   pk_valid, pk_ready, wf_valid, wf_ready;
  logic   re_valid, re_ready, rf_valid, rf_ready;
  wbeat_t pk_beat, wf_beat;
  rbeat_t re_beat, rf_beat;

  cmd_if cmd_fr ();
  cmd_if cmd_wr ();
  cmd_if cmd_rd ();

  // Fan the command out to both engines and merge what comes back
  assign cmd_wr.valid     = cmd_fr.valid;
  assign cmd_wr.cmd       = cmd_fr.cmd;
  assign cmd_rd.valid     = cmd_fr.valid;
  assign cmd_rd.cmd       = cmd_fr.cmd;
  assign cmd_fr.ready     = cmd_wr.ready || cmd_rd.ready;
  assign cmd_fr.done      = cmd_wr.done || cmd_rd.done;
  assign cmd_fr.resp_err  = (cmd_wr.done && cmd_wr.resp_err) ||
                            (cmd_rd.done && cmd_rd.resp_err);

  cmd_framer u_framer (
    .aclk, .aresetn,
    .cmd_vld_i, .cmd_ack_i, .cmd_dir_i, .cmd_tag_i, .cmd_len_i, .cmd_lun_i, .cmd_adr_i,
    .byte_in_i (dat_tvalid_i && dat_tready_o),
    .byte_out_i(dat_tvalid_o && dat_tready_i),
    .cmd_o     (cmd_fr.source),
    .busy_o    (busy),
    .cmd_err_o, .cmd_res_o
  );

  // Inbound bytes only flow during an open write command
  byte_packer u_packer (
    .aclk, .aresetn,
    .enable_i   (busy && !cmd_fr.cmd.dir),
    .in_valid_i (dat_tvalid_i),
    .in_ready_o (dat_tready_o),
    .in_data_i  (dat_tdata_i),
    .in_last_i  (dat_tlast_i),
    .out_valid_o(pk_valid),
    .out_ready_i(pk_ready),
    .out_beat_o (pk_beat)
  );

  stream_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(wbeat_t)) u_wr_fifo (
    .aclk, .aresetn,
    .s_valid_i(pk_valid), .s_ready_o(pk_ready), .s_data_i(pk_beat),
    .m_valid_o(wf_valid), .m_ready_i(wf_ready), .m_data_o(wf_beat)
  );

  axi_write_engine u_wr_engine (
    .aclk, .aresetn,
    .cmd_i       (cmd_wr.sink),
    .beat_valid_i(wf_valid),
    .beat_ready_o(wf_ready),
    .beat_i      (wf_beat),
    .awvalid_o, .awready_i, .awaddr_o, .awid_o, .awlen_o, .awburst_o,
    .wvalid_o, .wready_i, .wlast_o, .wstrb_o, .wdata_o,
    .bvalid_i, .bready_o, .bresp_i
  );

  axi_read_engine u_rd_engine (
    .aclk, .aresetn,
    .cmd_i       (cmd_rd.sink),
    .arvalid_o, .arready_i, .araddr_o, .arid_o, .arlen_o, .arburst_o,
    .rvalid_i, .rready_o, .rlast_i, .rresp_i, .rdata_i,
    .beat_valid_o(re_valid),
    .beat_ready_i(re_ready),
    .beat_o      (re_beat)
  );

  stream_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(rbeat_t)) u_rd_fifo (
    .aclk, .aresetn,
    .s_valid_i(re_valid), .s_ready_o(re_ready), .s_data_i(re_beat),
    .m_valid_o(rf_valid), .m_ready_i(rf_ready), .m_data_o(rf_beat)
  );

  byte_unpacker u_unpacker (
    .aclk, .aresetn,
    .in_valid_i (rf_valid),
    .in_ready_o (rf_ready),
    .in_beat_i  (rf_beat),
    .out_valid_o(dat_tvalid_o),
    .out_ready_i(dat_tready_i),
    .out_data_o (dat_tdata_o),
    .out_keep_o (dat_tkeep_o),
    .out_last_o (dat_tlast_o)
  );

endmodule

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [7:0]
) (
  input  logic     aclk,
  input  logic     aresetn,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  input  payload_t s_data_i,
  output logic     m_valid_o,
  input  logic     m_ready_i,
  output payload_t m_data_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          push;
  logic          pop;

  assign s_ready_o = count_q != (AW + 1)'(DEPTH);
  assign m_valid_o = count_q != '0;
  assign m_data_o  = mem[rd_ptr_q];

  assign push = s_valid_i && s_ready_o;
  assign pop  = m_valid_o && m_ready_i;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly, DEPTH need not be a power of two
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr_q] <= s_data_i;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the cmd_to_axi testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_cmd_to_axi -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
